// ==== source/armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // ========================================
  // Widths
  // ========================================
  localparam int instrWidth   = 32;
  localparam int flagWidth    = 4;            // NZCV
  localparam int aluCtrlWidth = 4;

  // ========================================
  // Condition field, bits 31:28
  // ========================================
  localparam logic [3:0] condEq     = 4'h0;   // Z set
  localparam logic [3:0] condNe     = 4'h1;
  localparam logic [3:0] condCs     = 4'h2;   // Carry set / unsigned higher or same
  localparam logic [3:0] condCc     = 4'h3;
  localparam logic [3:0] condMi     = 4'h4;
  localparam logic [3:0] condPl     = 4'h5;
  localparam logic [3:0] condVs     = 4'h6;
  localparam logic [3:0] condVc     = 4'h7;
  localparam logic [3:0] condHi     = 4'h8;
  localparam logic [3:0] condLs     = 4'h9;
  localparam logic [3:0] condGe     = 4'hA;
  localparam logic [3:0] condLt     = 4'hB;
  localparam logic [3:0] condGt     = 4'hC;
  localparam logic [3:0] condLe     = 4'hD;
  localparam logic [3:0] condAlways = 4'hE;

  // Data processing opcodes, bits 24:21
  localparam logic [3:0] opAnd = 4'h0;
  localparam logic [3:0] opEor = 4'h1;
  localparam logic [3:0] opSub = 4'h2;
  localparam logic [3:0] opRsb = 4'h3;
  localparam logic [3:0] opAdd = 4'h4;
  localparam logic [3:0] opAdc = 4'h5;
  localparam logic [3:0] opSbc = 4'h6;
  localparam logic [3:0] opRsc = 4'h7;
  localparam logic [3:0] opTst = 4'h8;
  localparam logic [3:0] opTeq = 4'h9;
  localparam logic [3:0] opCmp = 4'hA;
  localparam logic [3:0] opCmn = 4'hB;
  localparam logic [3:0] opOrr = 4'hC;
  localparam logic [3:0] opMov = 4'hD;
  localparam logic [3:0] opBic = 4'hE;
  localparam logic [3:0] opMvn = 4'hF;

  // Instruction class, bits 27:26
  localparam logic [1:0] classData   = 2'b00;
  localparam logic [1:0] classMem    = 2'b01;
  localparam logic [1:0] classBranch = 2'b10;

  localparam logic [3:0] pcReg = 4'd15;

  // ========================================
  // Instruction word views
  // ========================================
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;
    logic        immediate;                   // Operand2 is rotated immediate
    logic [3:0]  opcode;
    logic        sBit;                        // Set flags
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpFields;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  instrClass;
    logic        regOffset;                   // Offset from Rm, else 12-bit immediate
    logic        preIndex;
    logic        up;                          // Add offset, else subtract
    logic        byteBit;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFields;

  typedef union packed {
    dpFields  dp;
    memFields mem;
  } instrWord;

endpackage

`default_nettype wire

// ==== source/decodeIf.sv ====
`default_nettype none

// Decode controls from both decoders into Execute
interface decodeIf;
  // Main decoder side
  logic       aluSrc;                         // Immediate operand B
  logic       memtoReg;
  logic       regWrite;
  logic       memWrite;
  logic       branch;
  logic       byteAccess;
  logic       pcSrc;                          // Writes the PC
  logic [3:0] cond;

  // ALU decoder side
  logic [armCtrlPkg::aluCtrlWidth-1:0] aluControl;
  logic [1:0] flagWrite;                      // {NZ, CV}
  logic       noWrite;                        // Compare type, no Rd write

  modport mainSide (output aluSrc, memtoReg, regWrite, memWrite, branch, byteAccess,
                    pcSrc, cond);
  modport aluSide (output aluControl, flagWrite, noWrite);
  modport execute (input aluSrc, memtoReg, regWrite, memWrite, branch, byteAccess,
                   pcSrc, cond, aluControl, flagWrite, noWrite);
endinterface

`default_nettype wire

// ==== source/controlDecoder.sv ====
`default_nettype none

module controlDecoder (
  input  armCtrlPkg::instrWord instr,
  output logic [1:0]           regSrc,        // {store reads Rd, branch reads PC}
  output logic [1:0]           immSrc,        // 00 DP, 01 mem, 10 branch
  decodeIf.mainSide            ctrl
);

  logic [8:0] controls;
  logic       cmpType;                        // TST/TEQ/CMP/CMN space
  logic       extraSpace;                     // Multiply and halfword encodings

  assign cmpType    = (instr.dp.instrClass == armCtrlPkg::classData) &
                      (instr.dp.opcode[3:2] == 2'b10);
  assign extraSpace = ~instr.dp.immediate & instr.dp.operand2[7] & instr.dp.operand2[4];

  // Control word
  // regSrc_immSrc_aluSrc_memtoReg_regWrite_memWrite_branch
  always_comb begin
    controls = '0;                            // Unsupported words stay all zero
    case (instr.dp.instrClass)
      armCtrlPkg::classData: begin
        if (extraSpace)
          controls = '0;                      // MUL, LDRH/STRH not kept
        else if (cmpType & ~instr.dp.sBit)
          controls = '0;                      // MRS, MSR, BX share this space
        else if (instr.dp.immediate)
          controls = 9'b00_00_1_0_1_0_0;      // DP immediate
        else
          controls = 9'b00_00_0_0_1_0_0;      // DP register
      end
      armCtrlPkg::classMem: begin
        if (instr.mem.regOffset & instr.mem.offset[4])
          controls = '0;                      // Undefined space
        else if (instr.mem.load)
          controls = {2'b00, 2'b01, ~instr.mem.regOffset, 4'b1_1_0_0};   // LDR/LDRB
        else
          controls = {2'b10, 2'b01, ~instr.mem.regOffset, 4'b0_0_1_0};   // STR/STRB
      end
      armCtrlPkg::classBranch: controls = 9'b01_10_1_0_0_0_1;  // B, link bit ignored
      default: controls = '0;                 // Coprocessor, SWI
    endcase
  end

  assign {regSrc, immSrc, ctrl.aluSrc, ctrl.memtoReg, ctrl.regWrite,
          ctrl.memWrite, ctrl.branch} = controls;

  assign ctrl.byteAccess = instr.mem.byteBit & (ctrl.memtoReg | ctrl.memWrite);

  // Branch, or any real write to R15 (compares excluded)
  assign ctrl.pcSrc = ctrl.branch |
                      (ctrl.regWrite & ~cmpType & (instr.dp.rd == armCtrlPkg::pcReg));

  assign ctrl.cond = instr.dp.cond;           // Checked in Execute

endmodule

`default_nettype wire

// ==== source/aluDecoder.sv ====
`default_nettype none

module aluDecoder (
  input  armCtrlPkg::instrWord instr,
  decodeIf.aluSide             ctrl
);

  logic logicalOp;
  logic extraSpace;

  assign extraSpace = ~instr.dp.immediate & instr.dp.operand2[7] & instr.dp.operand2[4];

  // Logical ops leave C and V alone (no shifter carry)
  always_comb begin
    case (instr.dp.opcode)
      armCtrlPkg::opAnd, armCtrlPkg::opEor, armCtrlPkg::opTst, armCtrlPkg::opTeq,
      armCtrlPkg::opOrr, armCtrlPkg::opMov, armCtrlPkg::opBic,
      armCtrlPkg::opMvn: logicalOp = 1'b1;
      armCtrlPkg::opSub, armCtrlPkg::opRsb, armCtrlPkg::opAdd, armCtrlPkg::opAdc,
      armCtrlPkg::opSbc, armCtrlPkg::opRsc, armCtrlPkg::opCmp,
      armCtrlPkg::opCmn: logicalOp = 1'b0;
      default: logicalOp = 1'b0;
    endcase
  end

  always_comb begin
    ctrl.aluControl = armCtrlPkg::opAdd;      // Branch target and default
    ctrl.flagWrite  = 2'b00;
    ctrl.noWrite    = 1'b0;
    case (instr.dp.instrClass)
      armCtrlPkg::classData: begin
        ctrl.aluControl = instr.dp.opcode;    // Opcode goes straight to the ALU
        ctrl.flagWrite  = {2{instr.dp.sBit & ~extraSpace}} & {1'b1, ~logicalOp};
        ctrl.noWrite    = instr.dp.opcode[3:2] == 2'b10;  // TST TEQ CMP CMN
      end
      armCtrlPkg::classMem:                   // Rn +/- offset
        ctrl.aluControl = instr.mem.up ? armCtrlPkg::opAdd : armCtrlPkg::opSub;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`default_nettype none

module executeStage (
  input  logic                                  clk,
  input  logic                                  arstN,
  input  logic                                  stallE,
  input  logic                                  flushE,
  decodeIf.execute                              dec,
  input  logic [armCtrlPkg::flagWidth-1:0]      aluFlagsE,    // NZCV from the ALU
  output logic                                  aluSrcE,
  output logic [armCtrlPkg::aluCtrlWidth-1:0]   aluControlE,
  output logic                                  branchTakenE,
  output logic                                  memWriteE,
  output logic                                  memtoRegE,
  output logic                                  regWriteE,
  output logic                                  pcSrcE,
  output logic                                  byteE,
  output logic [armCtrlPkg::flagWidth-1:0]      flagsE        // Architectural NZCV
);

  logic       regWriteRaw, memWriteRaw, branchRaw, pcSrcRaw, noWriteE;
  logic [1:0] flagWriteE;                     // {NZ, CV}
  logic [3:0] condE;
  logic       condPass;
  logic       n, z, c, v;

  // ========================================
  // Execute pipeline register
  // ========================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      aluSrcE     <= 1'b0;
      aluControlE <= armCtrlPkg::opAnd;       // All-zero code
      memtoRegE   <= 1'b0;
      regWriteRaw <= 1'b0;
      memWriteRaw <= 1'b0;
      branchRaw   <= 1'b0;
      byteE       <= 1'b0;
      pcSrcRaw    <= 1'b0;
      flagWriteE  <= 2'b00;
      noWriteE    <= 1'b0;
      condE       <= '0;
    end else if (!stallE) begin               // Stall holds and masks flush
      if (flushE) begin
        // Bubble
        aluSrcE     <= 1'b0;
        aluControlE <= armCtrlPkg::opAnd;
        memtoRegE   <= 1'b0;
        regWriteRaw <= 1'b0;
        memWriteRaw <= 1'b0;
        branchRaw   <= 1'b0;
        byteE       <= 1'b0;
        pcSrcRaw    <= 1'b0;
        flagWriteE  <= 2'b00;
        noWriteE    <= 1'b0;
        condE       <= armCtrlPkg::condAlways;
      end else begin
        aluSrcE     <= dec.aluSrc;
        aluControlE <= dec.aluControl;
        memtoRegE   <= dec.memtoReg;
        regWriteRaw <= dec.regWrite;
        memWriteRaw <= dec.memWrite;
        branchRaw   <= dec.branch;
        byteE       <= dec.byteAccess;
        pcSrcRaw    <= dec.pcSrc;
        flagWriteE  <= dec.flagWrite;
        noWriteE    <= dec.noWrite;
        condE       <= dec.cond;
      end
    end
  end

  // ========================================
  // Condition check
  // ========================================
  assign {n, z, c, v} = flagsE;

  always_comb begin
    case (condE)
      armCtrlPkg::condEq:     condPass = z;
      armCtrlPkg::condNe:     condPass = ~z;
      armCtrlPkg::condCs:     condPass = c;
      armCtrlPkg::condCc:     condPass = ~c;
      armCtrlPkg::condMi:     condPass = n;
      armCtrlPkg::condPl:     condPass = ~n;
      armCtrlPkg::condVs:     condPass = v;
      armCtrlPkg::condVc:     condPass = ~v;
      armCtrlPkg::condHi:     condPass = c & ~z;
      armCtrlPkg::condLs:     condPass = ~c | z;
      armCtrlPkg::condGe:     condPass = (n == v);
      armCtrlPkg::condLt:     condPass = (n != v);
      armCtrlPkg::condGt:     condPass = ~z & (n == v);
      armCtrlPkg::condLe:     condPass = z | (n != v);
      armCtrlPkg::condAlways: condPass = 1'b1;
      default:                condPass = 1'b0;   // NV never executes
    endcase
  end

  // Flags, NZ and CV groups written separately
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsE <= '0;
    end else if (!stallE && condPass) begin
      if (flagWriteE[1]) flagsE[3:2] <= aluFlagsE[3:2];
      if (flagWriteE[0]) flagsE[1:0] <= aluFlagsE[1:0];
    end
  end

  // Gated controls
  assign branchTakenE = branchRaw & condPass;
  assign memWriteE    = memWriteRaw & condPass;
  assign regWriteE    = regWriteRaw & condPass & ~noWriteE;   // Compares write no Rd
  assign pcSrcE       = pcSrcRaw & condPass;

endmodule

`default_nettype wire

// ==== source/memWriteStages.sv ====
`default_nettype none

module memWriteStages (
  input  logic clk,
  input  logic arstN,
  input  logic stallM,
  input  logic stallW,
  input  logic flushW,
  input  logic memWriteE,                     // Already condition gated
  input  logic memtoRegE,
  input  logic regWriteE,
  input  logic pcSrcE,
  input  logic byteE,
  output logic memWriteM,
  output logic regWriteM,
  output logic pcSrcM,
  output logic byteM,
  output logic memtoRegW,
  output logic regWriteW,
  output logic pcSrcW
);

  logic memtoRegM;

  // Memory register, enable only
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM, byteM} <= '0;
    end else if (!stallM) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM, byteM} <=
        {memWriteE, memtoRegE, regWriteE, pcSrcE, byteE};
    end
  end

  // Writeback register, flush wins over stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    else if (flushW)
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    else if (!stallW)
      {memtoRegW, regWriteW, pcSrcW} <= {memtoRegM, regWriteM, pcSrcM};
  end

endmodule

`default_nettype wire

// ==== source/controller.sv ====
`default_nettype none

module controller (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic [armCtrlPkg::instrWidth-1:0]   instrD,
  input  logic [armCtrlPkg::flagWidth-1:0]    aluFlagsE,
  // Hazard unit
  input  logic                                stallE,
  input  logic                                flushE,
  input  logic                                stallM,
  input  logic                                stallW,
  input  logic                                flushW,
  // Datapath controls
  output logic [1:0]                          regSrcD,
  output logic [1:0]                          immSrcD,
  output logic                                aluSrcE,
  output logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlE,
  output logic                                branchTakenE,
  output logic                                memtoRegE,
  output logic [armCtrlPkg::flagWidth-1:0]    flagsE,
  output logic                                memWriteM,
  output logic                                regWriteM,
  output logic                                byteM,
  output logic                                memtoRegW,
  output logic                                regWriteW,
  output logic                                pcSrcW,
  output logic                                pcWrPendingF    // To hazard unit
);

  armCtrlPkg::instrWord instrU;
  logic memWriteE, regWriteE, pcSrcE, byteE;  // Execute to Memory
  logic pcSrcM;

  decodeIf decBus ();

  assign instrU = instrD;                     // Same bits, two views

  // ========================================
  // Decode
  // ========================================
  controlDecoder mainDec (
    .instr  (instrU),
    .regSrc (regSrcD),
    .immSrc (immSrcD),
    .ctrl   (decBus.mainSide)
  );

  aluDecoder aluDec (
    .instr (instrU),
    .ctrl  (decBus.aluSide)
  );

  // ========================================
  // Execute, Memory, Writeback
  // ========================================
  executeStage exStage (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .dec          (decBus.execute),
    .aluFlagsE    (aluFlagsE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .memWriteE    (memWriteE),
    .memtoRegE    (memtoRegE),
    .regWriteE    (regWriteE),
    .pcSrcE       (pcSrcE),
    .byteE        (byteE),
    .flagsE       (flagsE)
  );

  memWriteStages mwStages (
    .clk       (clk),
    .arstN     (arstN),
    .stallM    (stallM),
    .stallW    (stallW),
    .flushW    (flushW),
    .memWriteE (memWriteE),
    .memtoRegE (memtoRegE),
    .regWriteE (regWriteE),
    .pcSrcE    (pcSrcE),
    .byteE     (byteE),
    .memWriteM (memWriteM),
    .regWriteM (regWriteM),
    .pcSrcM    (pcSrcM),
    .byteM     (byteM),
    .memtoRegW (memtoRegW),
    .regWriteW (regWriteW),
    .pcSrcW    (pcSrcW)
  );

  // PC write in flight anywhere before Writeback
  assign pcWrPendingF = decBus.pcSrc | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

// ==== testbench/controller_checker.sv ====
`default_nettype none

module controllerChecker (
  input logic                                clk,
  input logic                                arstN,
  input logic                                stallE,
  input logic                                flushE,
  input logic                                stallM,
  input logic                                flushW,
  input logic                                memtoRegE,
  input logic                                aluSrcE,
  input logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlE,
  input logic [armCtrlPkg::flagWidth-1:0]    flagsE,
  input logic                                memWriteM,
  input logic                                regWriteW
);

  // ========================================
  // Pipeline rules
  // ========================================
  bubbleAfterFlush: assert property (@(posedge clk) disable iff (!arstN)
    flushE && !stallE |=> !memtoRegE && !aluSrcE)
    else $error("Execute not a bubble after flush");

  memHoldOnStall: assert property (@(posedge clk) disable iff (!arstN)
    stallM |=> $stable(memWriteM))
    else $error("memWriteM moved during Memory stall");

  wbClearOnFlush: assert property (@(posedge clk) disable iff (!arstN)
    flushW |=> !regWriteW)
    else $error("regWriteW high after Writeback flush");

  // Execute register and flags frozen by stallE
  execHoldOnStall: assert property (@(posedge clk) disable iff (!arstN)
    stallE |=> $stable(aluSrcE) && $stable(aluControlE) && $stable(flagsE))
    else $error("Execute outputs or flags moved during Execute stall");

endmodule

bind controller controllerChecker checkerInst (
  .clk         (clk),
  .arstN       (arstN),
  .stallE      (stallE),
  .flushE      (flushE),
  .stallM      (stallM),
  .flushW      (flushW),
  .memtoRegE   (memtoRegE),
  .aluSrcE     (aluSrcE),
  .aluControlE (aluControlE),
  .flagsE      (flagsE),
  .memWriteM   (memWriteM),
  .regWriteW   (regWriteW)
);

`default_nettype wire

// ==== testbench/tbController.sv ====
`default_nettype none

module tbController;

  localparam int resetCycles = 16;
  localparam int traceDepth  = 256;

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic        stallE, flushE, stallM, stallW, flushW;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE, memtoRegE;
  logic [3:0]  flagsE;
  logic        memWriteM, regWriteM, byteM;
  logic        memtoRegW, regWriteW, pcSrcW, pcWrPendingF;

  // One trace line: test, instr, flags, 5 hazard bits, 14 expected fields
  logic [119:0] trace [0:traceDepth-1];
  int traceLen;
  int cycleCount;
  int cycleLimit;
  int checkCount;
  int testErrors;
  int totalErrors;
  int testsOk;
  int testsBad;

  controller controller_inst (
    .clk          (clk),
    .arstN        (arstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .stallE       (stallE),
    .flushE       (flushE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .memtoRegE    (memtoRegE),
    .flagsE       (flagsE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .byteM        (byteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                       // Period 8

  // Run limit from trace length
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit != 0 && cycleCount > cycleLimit) begin
      $display("Timeout: run went past %0d cycles", cycleLimit);
      $display("test failed");
      $finish;
    end
  end

  task checkField(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      $display("Error at time %0t: %s expected %0h, actual %0h", $time, name, expVal, actVal);
      testErrors++;
    end
  endtask

  task checkOutputs(input logic [119:0] e);
    checkField("regSrcD",      32'(e[53:52]), 32'(regSrcD));
    checkField("immSrcD",      32'(e[49:48]), 32'(immSrcD));
    checkField("aluSrcE",      32'(e[44]),    32'(aluSrcE));
    checkField("aluControlE",  32'(e[43:40]), 32'(aluControlE));
    checkField("branchTakenE", 32'(e[36]),    32'(branchTakenE));
    checkField("memtoRegE",    32'(e[32]),    32'(memtoRegE));
    checkField("flagsE",       32'(e[31:28]), 32'(flagsE));
    checkField("memWriteM",    32'(e[24]),    32'(memWriteM));
    checkField("regWriteM",    32'(e[20]),    32'(regWriteM));
    checkField("byteM",        32'(e[16]),    32'(byteM));
    checkField("memtoRegW",    32'(e[12]),    32'(memtoRegW));
    checkField("regWriteW",    32'(e[8]),     32'(regWriteW));
    checkField("pcSrcW",       32'(e[4]),     32'(pcSrcW));
    checkField("pcWrPendingF", 32'(e[0]),     32'(pcWrPendingF));
  endtask

  task driveLine(input logic [119:0] e);
    instrD    = e[111:80];
    aluFlagsE = e[79:76];
    stallE    = e[72];
    flushE    = e[68];
    stallM    = e[64];
    stallW    = e[60];
    flushW    = e[56];
  endtask

  task closeTest(input int testNum);
    if (testErrors == 0)
      testsOk++;
    else
      testsBad++;
    $display("Test %0d finished: %0d checks, %0d errors", testNum, checkCount, testErrors);
    totalErrors += testErrors;
    checkCount = 0;
    testErrors = 0;
  endtask

  initial begin
    cycleLimit = 0;
    checkCount = 0;
    testErrors = 0;
    totalErrors = 0;
    testsOk = 0;
    testsBad = 0;
    arstN = 1'b0;
    driveLine('0);
    for (int i = 0; i < traceDepth; i++)
      trace[i] = '1;                          // Test tag FF marks the end
    $readmemh("testbench/controller_trace.txt", trace);
    traceLen = 0;
    while (traceLen < traceDepth && trace[traceLen][119:112] != 8'hFF)
      traceLen++;
    cycleLimit = traceLen + resetCycles + 20;

    // ========================================
    // Test 0: reset
    // ========================================
    for (int i = 0; i < resetCycles; i++) begin
      @(negedge clk);
      checkOutputs('0);                       // NOP word in, all controls low
    end
    arstN = 1'b1;
    closeTest(0);

    if (traceLen == 0) begin
      $display("Trace file holds no lines");
      totalErrors++;
    end

    // ========================================
    // Trace replay
    // ========================================
    for (int idx = 0; idx < traceLen; idx++) begin
      driveLine(trace[idx]);                  // On the falling edge
      @(negedge clk);
      checkOutputs(trace[idx]);
      if (idx == traceLen - 1 || trace[idx + 1][119:112] != trace[idx][119:112])
        closeTest(int'(trace[idx][119:112]));
    end

    // Idle edge so the last flush and stall rules resolve
    driveLine('0);
    @(negedge clk);

    $display("Tests ok: %0d, tests with errors: %0d", testsOk, testsBad);
    if (totalErrors == 0 && testsBad == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/controller_trace.txt ====
// test_instrD_aluFlagsE_{stallE flushE stallM stallW flushW}_
// {regSrcD immSrcD aluSrcE aluControlE branchTakenE memtoRegE flagsE}_
// {memWriteM regWriteM byteM memtoRegW regWriteW pcSrcW pcWrPendingF}
// Test 1: first cycles after reset
01_F0000000_0_00000_0000000_0000000
01_F0000000_0_00000_0000000_0000000
// Test 2: decode by class, ADD imm, SUB reg, LDR up, STR down, STRB, B
02_E2821005_0_00000_0014000_0000000
02_E0443005_0_00000_0002000_0100000
02_E5976008_0_00000_0114010_0100100
02_E5098004_0_00000_2112000_0100100
02_E5C21001_0_00000_2114000_1001100
02_EA000010_0_00000_1214100_1010001
02_F0000000_0_00000_0000000_0000001
02_F0000000_0_00000_0000000_0000010
02_F0000000_0_00000_0000000_0000000
// Test 3: ADDS, ANDS, BLT taken, BNE not taken, CMP
03_E0921003_0_00000_0004000_0000000
03_E0154006_9_00000_0000009_0100000
03_BA000004_6_00000_1214105_0100101
03_1A000004_F_00000_1214005_0000101
03_E1510002_0_00000_000A005_0000010
03_F0000000_8_00000_0000008_0000000
03_F0000000_0_00000_0000008_0000000
// Test 4: STRMI, STREQ fails, LDR, MOV pc
04_45098004_0_00000_2112008_0000000
04_05098004_0_00000_2112008_1000000
04_E5976008_0_00000_0114018_0000000
04_E1A0F001_0_00000_000D008_0100001
04_F0000000_0_00000_0000008_0101101
04_F0000000_0_00000_0000008_0000110
04_F0000000_0_00000_0000008_0000000
// Test 5: stallE, flushE bubbles, flushW
05_E0921003_0_00000_0004008_0000000
05_E5976008_3_10000_0104008_0100000
05_E5976008_3_01000_0100003_0100100
05_EA000010_0_01000_1200003_0000101
05_E2821005_0_00000_0014003_0000000
05_F0000000_0_00000_0000003_0100000
05_F0000000_0_00001_0000003_0000000

// ==== filelist.f ====
source/armCtrlPkg.sv
source/decodeIf.sv
source/controlDecoder.sv
source/aluDecoder.sv
source/executeStage.sv
source/memWriteStages.sv
source/controller.sv
testbench/controller_checker.sv
testbench/tbController.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tbController
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJDIR)
